// ==== eth_tx.f ====
+incdir+dv
hdl/eth_tx_pkg.sv
hdl/eth_tx_buffer.sv
hdl/eth_crc32.sv
hdl/eth_mii_tx.sv
hdl/eth_tx_top.sv
dv/eth_tx_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
   --top-module eth_tx_tb -Mdir obj_dir -f eth_tx.f

status=0
out=$(./obj_dir/Veth_tx_tb 2>&1) || status=$?
printf '%s\n' "$out"
if [ "$status" -eq 0 ] && printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
   exit 0
fi
exit 1

// ==== dv/eth_tx_model.svh ====
`ifndef eth_tx_model_svh
`define eth_tx_model_svh

typedef logic [7:0] byte_q_t[$];
typedef logic [3:0] nib_q_t[$];

// byte-wise reflected CRC-32, inverted as it goes on the wire
function automatic logic [31:0] fcs_of(input byte_q_t bytes);
   logic [31:0] crc;
   crc = 32'hffff_ffff;
   foreach (bytes[i]) begin
      crc = crc ^ {24'h0, bytes[i]};
      for (int b = 0; b < 8; b++) begin
         crc = crc[0] ? ((crc >> 1) ^ 32'hedb8_8320) : (crc >> 1);
      end
   end
   return ~crc;
endfunction

// whole frame as MII nibbles, low nibble of each byte first
function automatic nib_q_t frame_nibbles(input logic [47:0] dest, input logic [47:0] src,
                                         input byte_q_t payload);
   byte_q_t covered;
   byte_q_t frame;
   nib_q_t nibs;
   logic [31:0] fcs;
   // MAC addresses go lowest byte first
   for (int i = 0; i < 6; i++) begin
      covered.push_back(dest[8*i +: 8]);
   end
   for (int i = 0; i < 6; i++) begin
      covered.push_back(src[8*i +: 8]);
   end
   foreach (payload[i]) begin
      covered.push_back(payload[i]);
   end
   fcs = fcs_of(covered);
   for (int i = 0; i < 7; i++) begin
      frame.push_back(8'h55);
   end
   frame.push_back(8'hd5);
   foreach (covered[i]) begin
      frame.push_back(covered[i]);
   end
   for (int i = 0; i < 4; i++) begin
      frame.push_back(fcs[8*i +: 8]);
   end
   foreach (frame[i]) begin
      nibs.push_back(frame[i][3:0]);
      nibs.push_back(frame[i][7:4]);
   end
   return nibs;
endfunction

`endif

// ==== dv/eth_tx_tb.sv ====
`timescale 1ns/100ps

module eth_tx_tb;

   import eth_tx_pkg::*;

   `include "eth_tx_model.svh"

   localparam int n_frames = 12;
   localparam int max_len = 64;
   // longest frame plus handshake margin, per frame
   localparam int busy_limit = n_frames * (2 * (max_len + 24) + 20);

   logic                  TX_CLK;
   logic                  rst;
   logic                  buf_we;
   logic [buf_addr_w-1:0] buf_waddr;
   logic [data_w-1:0]     buf_wdata;
   send_cmd_t             send_cmd;
   logic                  req;
   logic                  ack;
   logic                  TX_EN;
   logic [3:0]            TX_DATA;

   integer  seed;
   int      busy_cycles = 0;
   byte_q_t payload;
   nib_q_t  expected;

   eth_tx_top eth_tx_top_inst (
      .TX_CLK    (TX_CLK),
      .rst       (rst),
      .buf_we    (buf_we),
      .buf_waddr (buf_waddr),
      .buf_wdata (buf_wdata),
      .send_cmd  (send_cmd),
      .req       (req),
      .ack       (ack),
      .TX_EN     (TX_EN),
      .TX_DATA   (TX_DATA)
   );

   initial begin
      TX_CLK = 1'b0;
      forever #4 TX_CLK = ~TX_CLK;
   end

   task automatic stop_run(input string line);
      $display("%s", line);
      $display("Finished with errors");
      $fatal(1, "simulation stopped at the first error");
   endtask

   // counts only cycles with a request or ack in flight
   always @(posedge TX_CLK) begin
      if (req || ack) begin
         busy_cycles = busy_cycles + 1;
      end
      if (busy_cycles > busy_limit) begin
         stop_run($sformatf("timeout: the DUT did not finish %0d frames within %0d cycles",
                            n_frames, busy_limit));
      end
   end

   task automatic check_quiet(input int cycles);
      repeat (cycles) begin
         @(negedge TX_CLK);
         assert (!TX_EN && TX_DATA == 4'h0 && !ack)
         else stop_run($sformatf("MISMATCH at %0t: MII or ack active before any request",
                                 $time));
      end
   endtask

   // random payload into the buffer, then random MACs into send_cmd
   task automatic load_frame();
      int          len;
      logic [31:0] r_hi;
      logic [31:0] r_lo;
      send_cmd_t   cmd;
      len = 1 + int'($unsigned($random(seed)) % max_len);
      payload.delete();
      for (int i = 0; i < len; i++) begin
         payload.push_back(8'($random(seed)));
         @(posedge TX_CLK);
         buf_we <= 1'b1;
         buf_waddr <= buf_addr_w'(i);
         buf_wdata <= payload[i];
      end
      r_hi = $random(seed);
      r_lo = $random(seed);
      cmd.dest_mac = {r_hi[15:0], r_lo};
      r_hi = $random(seed);
      r_lo = $random(seed);
      cmd.src_mac = {r_hi[15:0], r_lo};
      cmd.nbytes = buf_addr_w'(len);
      expected = frame_nibbles(cmd.dest_mac, cmd.src_mac, payload);
      @(posedge TX_CLK);
      buf_we <= 1'b0;
      send_cmd <= cmd;
   endtask

   task automatic send_frame();
      int high_cycles;
      int hold;
      @(posedge TX_CLK);
      req <= 1'b1;
      // req is sampled on this edge
      @(posedge TX_CLK);
      @(negedge TX_CLK);
      assert (!TX_EN)
      else stop_run($sformatf("MISMATCH at %0t: TX_EN high on the req edge", $time));
      high_cycles = 0;
      @(negedge TX_CLK);
      while (TX_EN) begin
         assert (high_cycles < expected.size())
         else stop_run($sformatf("MISMATCH at %0t: TX_EN still high after %0d nibbles",
                                 $time, high_cycles));
         assert (TX_DATA == expected[high_cycles])
         else stop_run($sformatf("MISMATCH at %0t: nibble %0d is %h, expected %h",
                                 $time, high_cycles, TX_DATA, expected[high_cycles]));
         high_cycles++;
         @(negedge TX_CLK);
      end
      assert (high_cycles == 2 * (payload.size() + 24))
      else stop_run($sformatf("MISMATCH at %0t: TX_EN high for %0d cycles, expected %0d",
                              $time, high_cycles, 2 * (payload.size() + 24)));
      assert (!ack)
      else stop_run($sformatf("MISMATCH at %0t: ack high before TX_EN fell", $time));
      @(negedge TX_CLK);
      assert (ack && !TX_EN)
      else stop_run($sformatf("MISMATCH at %0t: ack did not rise after TX_EN fell", $time));
      hold = int'($unsigned($random(seed)) % 4);
      repeat (hold) begin
         @(negedge TX_CLK);
         assert (ack && !TX_EN)
         else stop_run($sformatf("MISMATCH at %0t: ack dropped while req was high", $time));
      end
      @(posedge TX_CLK);
      req <= 1'b0;
      @(negedge TX_CLK);
      assert (ack)
      else stop_run($sformatf("MISMATCH at %0t: ack fell before req was seen low", $time));
      @(negedge TX_CLK);
      assert (!ack && !TX_EN)
      else stop_run($sformatf("MISMATCH at %0t: ack did not fall after req dropped", $time));
   endtask

   initial begin
      seed = 32'h810;
      rst = 1'b1;
      buf_we = 1'b0;
      buf_waddr = '0;
      buf_wdata = '0;
      send_cmd = '0;
      req = 1'b0;
      repeat (8) @(posedge TX_CLK);
      rst <= 1'b0;
      check_quiet(16);
      for (int f = 0; f < n_frames; f++) begin
         load_frame();
         send_frame();
      end
      $display("Finished with no errors");
      $finish;
   end

endmodule

// ==== hdl/eth_tx_top.sv ====
`timescale 1ns/100ps

module eth_tx_top (
   input  logic                               TX_CLK,
   input  logic                               rst,
   input  logic                               buf_we,
   input  logic [eth_tx_pkg::buf_addr_w-1:0]  buf_waddr,
   input  logic [eth_tx_pkg::data_w-1:0]      buf_wdata,
   input  eth_tx_pkg::send_cmd_t              send_cmd,
   input  logic                               req,
   output logic                               ack,
   output logic                               TX_EN,
   output logic [3:0]                         TX_DATA
);

   import eth_tx_pkg::*;

   logic                  tx_rst_meta;
   logic                  tx_rst;
   logic [buf_addr_w-1:0] rd_addr;
   logic [data_w-1:0]     rd_data;
   logic                  crc_clr;
   logic                  crc_en;
   logic [3:0]            crc_nibble;
   logic [crc_w-1:0]      crc_value;

   // assert at once, release two edges after rst falls
   always_ff @(posedge TX_CLK or posedge rst) begin
      if (rst) begin
         tx_rst_meta <= 1'b1;
         tx_rst <= 1'b1;
      end else begin
         tx_rst_meta <= 1'b0;
         tx_rst <= tx_rst_meta;
      end
   end

   eth_tx_buffer eth_tx_buffer_inst (
      .TX_CLK  (TX_CLK),
      .we      (buf_we),
      .waddr   (buf_waddr),
      .wdata   (buf_wdata),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   eth_mii_tx eth_mii_tx_inst (
      .TX_CLK     (TX_CLK),
      .rst        (tx_rst),
      .req        (req),
      .send_cmd   (send_cmd),
      .ack        (ack),
      .rd_addr    (rd_addr),
      .rd_data    (rd_data),
      .crc_clr    (crc_clr),
      .crc_en     (crc_en),
      .crc_nibble (crc_nibble),
      .crc_value  (crc_value),
      .TX_EN      (TX_EN),
      .TX_DATA    (TX_DATA)
   );

   eth_crc32 eth_crc32_inst (
      .TX_CLK    (TX_CLK),
      .rst       (tx_rst),
      .clr       (crc_clr),
      .en        (crc_en),
      .nibble    (crc_nibble),
      .crc_value (crc_value)
   );

endmodule

// ==== hdl/eth_mii_tx.sv ====
`timescale 1ns/100ps

module eth_mii_tx (
   input  logic                               TX_CLK,
   input  logic                               rst,
   input  logic                               req,
   input  eth_tx_pkg::send_cmd_t              send_cmd,
   output logic                               ack,
   output logic [eth_tx_pkg::buf_addr_w-1:0]  rd_addr,
   input  logic [eth_tx_pkg::data_w-1:0]      rd_data,
   output logic                               crc_clr,
   output logic                               crc_en,
   output logic [3:0]                         crc_nibble,
   input  logic [eth_tx_pkg::crc_w-1:0]       crc_value,
   output logic                               TX_EN,
   output logic [3:0]                         TX_DATA
);

   import eth_tx_pkg::*;

   // one bit wider than the length to hold header and fcs
   typedef logic [buf_addr_w:0] cnt_t;

   tx_state_t         state;
   cnt_t              byte_cnt;
   cnt_t              pay_end;
   cnt_t              frame_end;
   logic              sending;
   logic              frame_last;
   logic [3:0]        mac_idx;
   logic [1:0]        fcs_idx;
   logic [2*mac_addr_w-1:0] macs;
   logic [data_w-1:0] tx_byte;
   logic [3:0]        hold_hi;
   logic [3:0]        cur_nibble;

   assign sending = (state == low_nibble) || (state == high_nibble);

   // first byte past the payload, and the last fcs byte
   assign pay_end = cnt_t'(send_cmd.nbytes) + cnt_t'(hdr_bytes);
   assign frame_end = pay_end + cnt_t'(fcs_bytes - 1);
   assign frame_last = (byte_cnt == frame_end);

   // dest MAC sits in the low half so byte 0 is its lowest byte
   assign macs = {send_cmd.src_mac, send_cmd.dest_mac};
   assign mac_idx = 4'(byte_cnt - cnt_t'(sfd_pos + 1));
   assign fcs_idx = 2'(byte_cnt - pay_end);

   // fetch one byte ahead so rd_data is ready when the byte starts
   assign rd_addr = buf_addr_w'(byte_cnt - cnt_t'(hdr_bytes - 1));

   always_comb begin
      if (byte_cnt < cnt_t'(sfd_pos)) begin
         tx_byte = preamble_byte;
      end else if (byte_cnt == cnt_t'(sfd_pos)) begin
         tx_byte = sfd_byte;
      end else if (byte_cnt < cnt_t'(hdr_bytes)) begin
         tx_byte = macs[data_w*mac_idx +: data_w];
      end else if (byte_cnt < pay_end) begin
         tx_byte = rd_data;
      end else begin
         tx_byte = crc_value[data_w*fcs_idx +: data_w];
      end
   end

   // rd_data moves on during the high nibble, so keep the top half
   always_ff @(posedge TX_CLK) begin
      if (state == low_nibble) begin
         hold_hi <= tx_byte[7:4];
      end
   end

   assign cur_nibble = (state == high_nibble) ? hold_hi : tx_byte[3:0];

   // CRC covers MAC addresses and payload
   assign crc_clr = (state == idle) && req;
   assign crc_en = sending && (byte_cnt > cnt_t'(sfd_pos)) && (byte_cnt < pay_end);
   assign crc_nibble = cur_nibble;

   always_ff @(posedge TX_CLK or posedge rst) begin
      if (rst) begin
         state <= idle;
         byte_cnt <= '0;
         ack <= 1'b0;
         TX_EN <= 1'b0;
         TX_DATA <= 4'h0;
      end else begin
         // MII outputs trail the state by one cycle
         TX_EN <= sending;
         TX_DATA <= sending ? cur_nibble : 4'h0;
         case (state)
            idle: begin
               if (req) begin
                  state <= low_nibble;
                  byte_cnt <= '0;
               end
            end
            low_nibble: begin
               state <= high_nibble;
            end
            high_nibble: begin
               byte_cnt <= byte_cnt + 1'b1;
               if (frame_last) begin
                  state <= done_wait;
               end else begin
                  state <= low_nibble;
               end
            end
            done_wait: begin
               // ack waits for the last nibble to leave the MII
               if (ack && !req) begin
                  ack <= 1'b0;
                  state <= idle;
               end else if (!TX_EN) begin
                  ack <= 1'b1;
               end
            end
            default: begin
               state <= idle;
            end
         endcase
      end
   end

   // frame ends only on a byte boundary
   a_en_fall: assert property (@(posedge TX_CLK) disable iff (rst)
      $fell(TX_EN) |-> $past(state, 2) == high_nibble);

   // ack is low once req has stayed low past one edge
   a_ack_req: assert property (@(posedge TX_CLK) disable iff (rst)
      (!req && $past(!req)) |-> !ack);

   // quiet line for two cycles means nothing is in flight
   a_quiet_idle: assert property (@(posedge TX_CLK) disable iff (rst)
      (!TX_EN && !ack && $past(!TX_EN && !ack)) |->
      (state == idle || $past(state) == idle));

endmodule

// ==== hdl/eth_crc32.sv ====
`timescale 1ns/100ps

module eth_crc32 (
   input  logic                          TX_CLK,
   input  logic                          rst,
   input  logic                          clr,
   input  logic                          en,
   input  logic [3:0]                    nibble,
   output logic [eth_tx_pkg::crc_w-1:0]  crc_value
);

   import eth_tx_pkg::*;

   logic [crc_w-1:0] crc_reg;

   // four serial steps, bit 0 of the nibble goes in first
   function automatic logic [crc_w-1:0] crc_step(
      input logic [crc_w-1:0] crc_in,
      input logic [3:0]       nib
   );
      logic [crc_w-1:0] crc;
      logic             fb;
      crc = crc_in;
      for (int i = 0; i < 4; i++) begin
         fb = crc[0] ^ nib[i];
         crc = crc >> 1;
         if (fb) begin
            crc = crc ^ crc_poly;
         end
      end
      return crc;
   endfunction

   always_ff @(posedge TX_CLK or posedge rst) begin
      if (rst) begin
         crc_reg <= crc_init;
      end else if (clr) begin
         crc_reg <= crc_init;
      end else if (en) begin
         crc_reg <= crc_step(crc_reg, nibble);
      end
   end

   assign crc_value = crc_reg ^ crc_residue_inv;

   // the transmitter clears only while idle and feeds only while sending
   a_clr_en_excl: assert property (@(posedge TX_CLK) disable iff (rst) !(clr && en));

endmodule

// ==== hdl/eth_tx_buffer.sv ====
`timescale 1ns/100ps

module eth_tx_buffer (
   input  logic                               TX_CLK,
   input  logic                               we,
   input  logic [eth_tx_pkg::buf_addr_w-1:0]  waddr,
   input  logic [eth_tx_pkg::data_w-1:0]      wdata,
   input  logic [eth_tx_pkg::buf_addr_w-1:0]  rd_addr,
   output logic [eth_tx_pkg::data_w-1:0]      rd_data
);

   import eth_tx_pkg::*;

   // one byte per payload position
   logic [data_w-1:0] mem [2**buf_addr_w];

   // host side write port
   always_ff @(posedge TX_CLK) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
   end

   // transmitter side, one cycle read latency
   always_ff @(posedge TX_CLK) begin
      rd_data <= mem[rd_addr];
   end

endmodule

// ==== hdl/eth_tx_pkg.sv ====
package eth_tx_pkg;

   // buffer and frame widths
   localparam int buf_addr_w = 11;
   localparam int data_w = 8;
   localparam int mac_addr_w = 48;
   localparam int crc_w = 32;

   localparam logic [data_w-1:0] preamble_byte = 8'h55;
   localparam logic [data_w-1:0] sfd_byte = 8'hd5;

   // frame layout in bytes
   localparam int mac_bytes = mac_addr_w / data_w;
   localparam int hdr_bytes = 20;
   localparam int fcs_bytes = 4;
   // sfd is the last byte before the two MAC addresses
   localparam int sfd_pos = hdr_bytes - 2 * mac_bytes - 1;

   // reflected CRC-32 as used by the Ethernet FCS
   localparam logic [crc_w-1:0] crc_poly = 32'hedb88320;
   localparam logic [crc_w-1:0] crc_init = '1;
   localparam logic [crc_w-1:0] crc_residue_inv = '1;

   // done_wait holds ack until req falls
   typedef enum logic [1:0] {
      idle,
      low_nibble,
      high_nibble,
      done_wait
   } tx_state_t;

   // held stable by the host while req is high
   typedef struct packed {
      logic [buf_addr_w-1:0] nbytes;
      logic [mac_addr_w-1:0] src_mac;
      logic [mac_addr_w-1:0] dest_mac;
   } send_cmd_t;

endpackage
